// File: src/md_defs.svh
`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// Operand and HI/LO register width
`define MD_WORD_WIDTH 32

////////////////////
// Instruction encoding
////////////////////

// Primary opcode of R-type instructions
`define MD_OP_SPECIAL 6'b000000

`define MD_FUNCT_MFHI  6'b010000
`define MD_FUNCT_MTHI  6'b010001
`define MD_FUNCT_MFLO  6'b010010
`define MD_FUNCT_MTLO  6'b010011
`define MD_FUNCT_MULT  6'b011000
`define MD_FUNCT_MULTU 6'b011001
`define MD_FUNCT_DIV   6'b011010
`define MD_FUNCT_DIVU  6'b011011

// Stall lengths, issue cycle included
`define MD_MULT_CYCLES 5
`define MD_DIV_CYCLES  10
`define MD_TIMER_WIDTH 4

`endif

// File: src/md_pkg.sv
package md_pkg;

	////////////////////
	// Decoded operations
	////////////////////

	typedef enum logic [3:0] {
		MD_NONE  = 4'd0,
		MD_MULT  = 4'd1,
		MD_MULTU = 4'd2,
		MD_DIV   = 4'd3,
		MD_DIVU  = 4'd4,
		MD_MFHI  = 4'd5,
		MD_MFLO  = 4'd6,
		MD_MTHI  = 4'd7,
		MD_MTLO  = 4'd8
	} md_op_e;

	// Controller states
	typedef enum logic [1:0] {
		MD_IDLE = 2'd0,
		MD_BUSY = 2'd1,
		MD_DONE = 2'd2
	} md_state_e;

endpackage

// File: src/md_decode.sv
`timescale 1ns/10ps

`include "md_defs.svh"

module md_decode (
	input  logic [`MD_WORD_WIDTH-1:0] instr,
	output md_pkg::md_op_e            op
);

	import md_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;

	// Primary opcode and function field
	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	always_comb begin
		op = MD_NONE;
		if (opcode == `MD_OP_SPECIAL) begin
			case (funct)
				`MD_FUNCT_MULT: begin
					op = MD_MULT;
				end
				`MD_FUNCT_MULTU: begin
					op = MD_MULTU;
				end
				`MD_FUNCT_DIV: begin
					op = MD_DIV;
				end
				`MD_FUNCT_DIVU: begin
					op = MD_DIVU;
				end
				`MD_FUNCT_MFHI: begin
					op = MD_MFHI;
				end
				`MD_FUNCT_MFLO: begin
					op = MD_MFLO;
				end
				`MD_FUNCT_MTHI: begin
					op = MD_MTHI;
				end
				`MD_FUNCT_MTLO: begin
					op = MD_MTLO;
				end
				default: begin
					op = MD_NONE;
				end
			endcase
		end
	end

endmodule

// File: src/md_control.sv
`timescale 1ns/10ps

`include "md_defs.svh"

module md_control (
	input  logic                       clk,
	input  logic                       rst,
	input  md_pkg::md_op_e             op,
	input  logic                       expired,
	output logic                       stall,
	output logic                       start,
	output logic [`MD_TIMER_WIDTH-1:0] timer_load_cycles,
	output logic                       commit,
	output logic                       mt_enable
);

	import md_pkg::*;

	md_state_e state;
	logic      long_op;
	logic      is_mult;

	assign is_mult = (op == MD_MULT) || (op == MD_MULTU);
	assign long_op = is_mult || (op == MD_DIV) || (op == MD_DIVU);

	// Busy phase lasts load + 1 cycles, issue cycle adds one more
	assign timer_load_cycles = is_mult ? `MD_TIMER_WIDTH'(`MD_MULT_CYCLES - 2)
	                                   : `MD_TIMER_WIDTH'(`MD_DIV_CYCLES - 2);

	////////////////////
	// State register
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MD_IDLE;
		end else begin
			case (state)
				MD_IDLE: begin
					if (long_op) state <= MD_BUSY;
				end
				MD_BUSY: begin
					if (expired) state <= MD_DONE;
				end
				default: begin
					// Done cycle lets the finished instruction leave
					state <= MD_IDLE;
				end
			endcase
		end
	end

	////////////////////
	// Outputs
	////////////////////

	always_comb begin
		stall     = 1'b0;
		start     = 1'b0;
		commit    = 1'b0;
		mt_enable = 1'b0;
		case (state)
			MD_IDLE: begin
				stall     = long_op;
				start     = long_op;
				mt_enable = 1'b1;
			end
			MD_BUSY: begin
				stall  = 1'b1;
				commit = expired;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: src/md_cycle_timer.sv
`timescale 1ns/10ps

`include "md_defs.svh"

module md_cycle_timer (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       load,
	input  logic [`MD_TIMER_WIDTH-1:0] load_cycles,
	output logic                       expired
);

	logic [`MD_TIMER_WIDTH-1:0] count;
	logic                       armed;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
			armed <= 1'b0;
		end else if (load) begin
			count <= load_cycles;
			armed <= 1'b1;
		end else if (armed) begin
			// Disarm once expiry has been reported
			if (count == '0) begin
				armed <= 1'b0;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	// Never flags while idle
	assign expired = armed && (count == '0);

endmodule

// File: src/md_arith.sv
`timescale 1ns/10ps

`include "md_defs.svh"

module md_arith (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	input  md_pkg::md_op_e            op,
	input  logic [`MD_WORD_WIDTH-1:0] rs_data,
	input  logic [`MD_WORD_WIDTH-1:0] rt_data,
	output logic [`MD_WORD_WIDTH-1:0] pending_hi,
	output logic [`MD_WORD_WIDTH-1:0] pending_lo
);

	import md_pkg::*;

	logic signed [2*`MD_WORD_WIDTH-1:0] prod_s;
	logic        [2*`MD_WORD_WIDTH-1:0] prod_u;
	logic        [`MD_WORD_WIDTH-1:0]   next_hi;
	logic        [`MD_WORD_WIDTH-1:0]   next_lo;
	logic                               div_zero;
	logic                               div_ovf;

	////////////////////
	// Products
	////////////////////

	assign prod_s = $signed({{`MD_WORD_WIDTH{rs_data[`MD_WORD_WIDTH-1]}}, rs_data})
	              * $signed({{`MD_WORD_WIDTH{rt_data[`MD_WORD_WIDTH-1]}}, rt_data});
	assign prod_u = {{`MD_WORD_WIDTH{1'b0}}, rs_data} * {{`MD_WORD_WIDTH{1'b0}}, rt_data};

	// Special divide cases
	assign div_zero = (rt_data == '0);
	assign div_ovf  = (rs_data == {1'b1, {(`MD_WORD_WIDTH-1){1'b0}}}) && (rt_data == '1);

	always_comb begin
		next_hi = '0;
		next_lo = '0;
		case (op)
			MD_MULT: begin
				{next_hi, next_lo} = prod_s;
			end
			MD_MULTU: begin
				{next_hi, next_lo} = prod_u;
			end
			MD_DIV: begin
				if (div_zero) begin
					next_hi = rs_data;
					next_lo = '1;
				end else if (div_ovf) begin
					// Most negative over minus one wraps to itself
					next_hi = '0;
					next_lo = rs_data;
				end else begin
					next_hi = $signed(rs_data) % $signed(rt_data);
					next_lo = $signed(rs_data) / $signed(rt_data);
				end
			end
			MD_DIVU: begin
				if (div_zero) begin
					next_hi = rs_data;
					next_lo = '1;
				end else begin
					next_hi = rs_data % rt_data;
					next_lo = rs_data / rt_data;
				end
			end
			default: begin
			end
		endcase
	end

	// Held through the busy period
	always_ff @(posedge clk) begin
		if (rst) begin
			pending_hi <= '0;
			pending_lo <= '0;
		end else if (start) begin
			pending_hi <= next_hi;
			pending_lo <= next_lo;
		end
	end

endmodule

// File: src/hilo_regs.sv
`timescale 1ns/10ps

`include "md_defs.svh"

module hilo_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  md_pkg::md_op_e            op,
	input  logic                      commit,
	input  logic                      mt_enable,
	input  logic [`MD_WORD_WIDTH-1:0] pending_hi,
	input  logic [`MD_WORD_WIDTH-1:0] pending_lo,
	input  logic [`MD_WORD_WIDTH-1:0] rs_data,
	output logic [`MD_WORD_WIDTH-1:0] hl_data
);

	import md_pkg::*;

	logic [`MD_WORD_WIDTH-1:0] hi;
	logic [`MD_WORD_WIDTH-1:0] lo;

	////////////////////
	// Architectural HI/LO
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			hi <= '0;
			lo <= '0;
		end else if (commit) begin
			hi <= pending_hi;
			lo <= pending_lo;
		end else if (mt_enable) begin
			if (op == MD_MTHI) hi <= rs_data;
			if (op == MD_MTLO) lo <= rs_data;
		end
	end

	// Move-from read, zero for anything else
	always_comb begin
		case (op)
			MD_MFHI: begin
				hl_data = hi;
			end
			MD_MFLO: begin
				hl_data = lo;
			end
			default: begin
				hl_data = '0;
			end
		endcase
	end

endmodule

// File: src/md_unit.sv
`timescale 1ns/10ps

`include "md_defs.svh"

module md_unit (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [`MD_WORD_WIDTH-1:0] instr,
	input  logic [`MD_WORD_WIDTH-1:0] rs_data,
	input  logic [`MD_WORD_WIDTH-1:0] rt_data,
	output logic [`MD_WORD_WIDTH-1:0] hl_data,
	output logic                      stall
);

	import md_pkg::*;

	md_op_e                     op;
	logic                       start;
	logic [`MD_TIMER_WIDTH-1:0] timer_load_cycles;
	logic                       commit;
	logic                       mt_enable;
	logic                       expired;
	logic [`MD_WORD_WIDTH-1:0]  pending_hi;
	logic [`MD_WORD_WIDTH-1:0]  pending_lo;

	md_decode u_decode (
		.instr (instr),
		.op    (op)
	);

	////////////////////
	// Sequencing
	////////////////////

	md_control u_control (
		.clk               (clk),
		.rst               (rst),
		.op                (op),
		.expired           (expired),
		.stall             (stall),
		.start             (start),
		.timer_load_cycles (timer_load_cycles),
		.commit            (commit),
		.mt_enable         (mt_enable)
	);

	md_cycle_timer u_timer (
		.clk         (clk),
		.rst         (rst),
		.load        (start),
		.load_cycles (timer_load_cycles),
		.expired     (expired)
	);

	////////////////////
	// Datapath
	////////////////////

	md_arith u_arith (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.op         (op),
		.rs_data    (rs_data),
		.rt_data    (rt_data),
		.pending_hi (pending_hi),
		.pending_lo (pending_lo)
	);

	hilo_regs u_hilo (
		.clk        (clk),
		.rst        (rst),
		.op         (op),
		.commit     (commit),
		.mt_enable  (mt_enable),
		.pending_hi (pending_hi),
		.pending_lo (pending_lo),
		.rs_data    (rs_data),
		.hl_data    (hl_data)
	);

endmodule

// File: verification/md_tb_model.svh
`ifndef MD_TB_MODEL_SVH
`define MD_TB_MODEL_SVH

// Shadow of the architectural HI/LO
logic [`MD_WORD_WIDTH-1:0] model_hi;
logic [`MD_WORD_WIDTH-1:0] model_lo;

function automatic logic [31:0] encode(input logic [5:0] funct);
	return {`MD_OP_SPECIAL, 20'd0, funct};
endfunction

function automatic int latency(input logic [5:0] funct);
	if (funct == `MD_FUNCT_MULT || funct == `MD_FUNCT_MULTU) begin
		return `MD_MULT_CYCLES;
	end
	return `MD_DIV_CYCLES;
endfunction

////////////////////
// Expected {hi, lo}
////////////////////

function automatic logic [63:0] model_result(input logic [5:0] funct, input logic [31:0] a,
		input logic [31:0] b);
	longint          sa;
	longint          sb;
	longint unsigned ua;
	longint unsigned ub;
	logic [63:0]     res;
	sa  = longint'($signed(a));
	sb  = longint'($signed(b));
	ua  = {32'd0, a};
	ub  = {32'd0, b};
	res = '0;
	case (funct)
		`MD_FUNCT_MULT: res = sa * sb;
		`MD_FUNCT_MULTU: res = ua * ub;
		`MD_FUNCT_DIV: begin
			// Wide divide, so most negative over minus one wraps on truncation
			if (b == '0) res = {a, 32'hffff_ffff};
			else res = {32'(sa % sb), 32'(sa / sb)};
		end
		`MD_FUNCT_DIVU: begin
			if (b == '0) res = {a, 32'hffff_ffff};
			else res = {32'(ua % ub), 32'(ua / ub)};
		end
		default: res = '0;
	endcase
	return res;
endfunction

`endif

// File: verification/md_unit_tb.sv
`timescale 1ns/10ps

`include "md_defs.svh"

module md_unit_tb;

	logic                      clk;
	logic                      rst;
	logic [`MD_WORD_WIDTH-1:0] instr;
	logic [`MD_WORD_WIDTH-1:0] rs_data;
	logic [`MD_WORD_WIDTH-1:0] rt_data;
	logic [`MD_WORD_WIDTH-1:0] hl_data;
	logic                      stall;
	logic [15:0]               lfsr;

	logic [31:0] edge_words [5] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h1, 32'h7fff_ffff};
	logic [5:0]  long_ops [4] = '{`MD_FUNCT_MULT, `MD_FUNCT_MULTU, `MD_FUNCT_DIV, `MD_FUNCT_DIVU};

	md_unit dut0 (
		.clk     (clk),
		.rst     (rst),
		.instr   (instr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.hl_data (hl_data),
		.stall   (stall)
	);

	always #10 clk = ~clk;

	task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		$display("CHECKS FAILED");
	endtask

	task automatic fail_text(input string what);
		$display("ERROR: %s", what);
		$display("CHECKS FAILED");
	endtask

	// Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_word();
		logic [31:0] word;
		int          i;
		word = '0;
		for (i = 0; i < 32; i++) begin
			lfsr = lfsr_step(lfsr);
			word = {word[30:0], lfsr[0]};
		end
		return word;
	endfunction

	`include "md_tb_model.svh"

	////////////////////
	// Issue and check
	////////////////////

	task automatic drive(input logic [31:0] i, input logic [31:0] rs, input logic [31:0] rt);
		@(posedge clk);
		#1;
		instr   = i;
		rs_data = rs;
		rt_data = rt;
	endtask

	task automatic expect_stall_low();
		assert (!stall) else begin
			fail_value("stall", {31'd0, stall}, 32'd0);
			$fatal(1);
		end
	endtask

	// Anything but a move-from reads zero
	task automatic expect_read_zero(input string name);
		assert (hl_data == '0) else begin
			fail_value(name, hl_data, 32'd0);
			$fatal(1);
		end
	endtask

	task automatic check_read(input logic [5:0] funct, input logic [31:0] exp, input string name);
		drive(encode(funct), rand_word(), rand_word());
		@(negedge clk);
		expect_stall_low();
		assert (hl_data == exp) else begin
			fail_value(name, hl_data, exp);
			$fatal(1);
		end
	endtask

	task automatic check_hilo();
		check_read(`MD_FUNCT_MFHI, model_hi, "hl_data (MFHI)");
		check_read(`MD_FUNCT_MFLO, model_lo, "hl_data (MFLO)");
	endtask

	task automatic move_to(input logic [5:0] funct, input logic [31:0] value);
		drive(encode(funct), value, rand_word());
		@(negedge clk);
		expect_stall_low();
		expect_read_zero("hl_data (move-to)");
		if (funct == `MD_FUNCT_MTHI) begin
			model_hi = value;
		end else begin
			model_lo = value;
		end
	endtask

	task automatic run_long(input logic [5:0] funct, input logic [31:0] a, input logic [31:0] b,
			input logic scramble);
		logic [63:0] expected;
		int          cycles;
		expected = model_result(funct, a, b);
		cycles   = 0;
		drive(encode(funct), a, b);
		@(negedge clk);
		while (stall && cycles < 4 * `MD_DIV_CYCLES) begin
			cycles++;
			expect_read_zero("hl_data (busy)");
			// Operands may change once the instruction has issued
			@(posedge clk);
			#1;
			if (scramble) begin
				rs_data = rand_word();
				rt_data = rand_word();
			end
			@(negedge clk);
		end
		assert (!stall) else begin
			fail_text("stall did not fall before the timeout");
			$fatal(1);
		end
		assert (cycles == latency(funct)) else begin
			fail_value("stall cycles", 32'(cycles), 32'(latency(funct)));
			$fatal(1);
		end
		model_hi = expected[63:32];
		model_lo = expected[31:0];
	endtask

	initial begin
		int op_idx;
		int a_idx;
		int b_idx;
		int n;
		clk      = 1'b0;
		rst      = 1'b1;
		instr    = '0;
		rs_data  = '0;
		rt_data  = '0;
		lfsr     = 16'd19068;
		model_hi = '0;
		model_lo = '0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		// Reset values with a NOP presented
		@(negedge clk);
		expect_stall_low();
		expect_read_zero("hl_data (NOP)");
		check_hilo();

		move_to(`MD_FUNCT_MTHI, rand_word());
		move_to(`MD_FUNCT_MTLO, rand_word());
		check_hilo();

		// Each long op on all edge operand pairs and on random ones
		for (op_idx = 0; op_idx < 4; op_idx++) begin
			for (a_idx = 0; a_idx < 5; a_idx++) begin
				for (b_idx = 0; b_idx < 5; b_idx++) begin
					run_long(long_ops[op_idx], edge_words[a_idx], edge_words[b_idx], 1'b0);
					check_hilo();
				end
			end
			for (n = 0; n < 6; n++) begin
				run_long(long_ops[op_idx], rand_word(), rand_word(), 1'b0);
				check_hilo();
			end
		end

		// Operands change while busy
		for (op_idx = 0; op_idx < 4; op_idx++) begin
			run_long(long_ops[op_idx], rand_word(), rand_word(), 1'b1);
			check_hilo();
		end

		// Back to back issue right after each done cycle
		run_long(`MD_FUNCT_MULT, rand_word(), rand_word(), 1'b1);
		run_long(`MD_FUNCT_DIV, rand_word(), rand_word(), 1'b0);
		run_long(`MD_FUNCT_MULTU, rand_word(), rand_word(), 1'b0);
		check_hilo();
		run_long(`MD_FUNCT_DIVU, rand_word(), rand_word(), 1'b0);
		move_to(`MD_FUNCT_MTLO, rand_word());
		check_hilo();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: md_unit.f
+incdir+src
+incdir+verification
src/md_pkg.sv
src/md_decode.sv
src/md_control.sv
src/md_cycle_timer.sv
src/md_arith.sv
src/hilo_regs.sv
src/md_unit.sv
verification/md_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the md_unit testbench with Verilator and run it
# A failing check ends in $fatal, which gives a non-zero exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps -f md_unit.f \
	--top-module md_unit_tb -o md_unit_sim &&
./obj_dir/md_unit_sim ||
exit 1
